// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define WORD_WIDTH      32
`define OPCODE_WIDTH    6
`define FUNCT_WIDTH     6
`define IMM_WIDTH       16

// register file
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32

// instruction memory, word addressed
`define IMEM_DEPTH      256
`define IMEM_ADDR_WIDTH 8

// data memory, word addressed
`define DMEM_DEPTH      256
`define DMEM_ADDR_WIDTH 8

`endif

// File: isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

    typedef logic [`WORD_WIDTH-1:0]      word_t;
    typedef logic [`WORD_WIDTH-1:0]      instr_t;
    typedef logic [`REG_ADDR_WIDTH-1:0]  reg_idx_t;
    typedef logic [`IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [`IMM_WIDTH-1:0]       imm_t;

    // bits 31:26 of every instruction
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_rtype = 6'd0,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_addi  = 6'd8,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    // bits 5:0, only meaningful for op_rtype
    typedef enum logic [`FUNCT_WIDTH-1:0] {
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_slt = 6'd42
    } funct_e;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_t;

    typedef logic [1:0] mem_ctl_t;

    // bit positions inside mem_ctl_t
    localparam int mem_rd_bit = 0;
    localparam int mem_wr_bit = 1;

endpackage

// File: pipe_if.sv
`timescale 1ns/1ps

interface hazard_if
    import isa_pkg::*;
();
    logic     if_hold;
    logic     id_flush;
    logic     ex_bubble;
    logic     pipe_clear;

    logic     id_is_branch;
    logic     id_uses_rt;
    logic     branch_taken;
    reg_idx_t id_rs;
    reg_idx_t id_rt;

    reg_idx_t ex_dest;
    logic     ex_writes;
    logic     ex_is_load;

    reg_idx_t mem_dest;
    logic     mem_writes;

    modport ctl (
        input  id_rs, id_rt, id_uses_rt, id_is_branch, branch_taken,
        input  ex_dest, ex_writes, ex_is_load, mem_dest, mem_writes,
        output if_hold, id_flush, ex_bubble, pipe_clear
    );
    modport fetch (input if_hold, id_flush, pipe_clear);
    modport decode (
        input  ex_bubble, pipe_clear,
        output id_rs, id_rt, id_uses_rt, id_is_branch, branch_taken
    );
    modport execute (input pipe_clear, output ex_dest, ex_writes, ex_is_load);
    modport mem (input pipe_clear, output mem_dest, mem_writes);
endinterface

interface wb_if
    import isa_pkg::*;
();
    // writeback stage
    logic     valid;
    reg_idx_t idx;
    word_t    data;

    // instruction currently in MEM
    logic     is_load_mem;
    logic     mem_valid_write;
    reg_idx_t mem_idx;
    word_t    mem_data;

    modport src (output valid, idx, data, is_load_mem, mem_valid_write, mem_idx, mem_data);
    modport sink (input valid, idx, data, is_load_mem, mem_valid_write, mem_idx, mem_data);
endinterface

// File: fetch_stage.sv
`include "cpu_params.svh"
`timescale 1ns/1ps

module fetch_stage
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  instr_t     load_data,
    hazard_if.fetch    hz,
    input  word_t      branch_target,
    output word_t      id_pc,
    output instr_t     id_instr,
    output logic       id_valid
);

    word_t      pc;
    imem_addr_t fetch_idx;

    // zero words decode as nops
    instr_t imem [`IMEM_DEPTH] = '{default: '0};

    assign fetch_idx = pc[`IMEM_ADDR_WIDTH+1:2];

    // program load, only while the core is held
    always_ff @(posedge clk) begin
        if (hz.pipe_clear && load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || hz.pipe_clear) begin
            pc <= '0;
        end else if (hz.id_flush) begin
            pc <= branch_target;
        end else if (!hz.if_hold) begin
            pc <= pc + word_t'(4);
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (!rst_n || hz.pipe_clear) begin
            id_valid <= 1'b0;
        end else if (hz.id_flush) begin
            id_valid <= 1'b0;
        end else if (!hz.if_hold) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.if_hold) begin
            id_pc    <= pc;
            id_instr <= imem[fetch_idx];
        end
    end

endmodule

// File: decode_stage.sv
`include "cpu_params.svh"
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     id_pc,
    input  instr_t    id_instr,
    input  logic      id_valid,
    hazard_if.decode  hz,
    wb_if.sink        wb,
    output word_t     branch_target,
    output word_t     ex_a,
    output word_t     ex_b,
    output word_t     ex_store,
    output reg_idx_t  ex_rs,
    output reg_idx_t  ex_rt,
    output reg_idx_t  ex_dest,
    output alu_op_t   ex_alu_op,
    output mem_ctl_t  ex_mem_ctl,
    output logic      ex_writes,
    output logic      ex_valid
);

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs, rt, rd, dest, src_rt;
    imm_t     imm;
    word_t    imm_ext, rs_val, rt_val;
    alu_op_t  alu_op;
    mem_ctl_t mem_ctl;
    logic     writes, b_imm, uses_rt, is_beq, is_bne, operands_eq;

    word_t regs [`REG_COUNT];

    assign opcode  = opcode_e'(id_instr[`WORD_WIDTH-1 -: `OPCODE_WIDTH]);
    assign funct   = funct_e'(id_instr[`FUNCT_WIDTH-1:0]);
    assign rs      = id_instr[25:21];
    assign rt      = id_instr[20:16];
    assign rd      = id_instr[15:11];
    assign imm     = id_instr[`IMM_WIDTH-1:0];
    assign imm_ext = {{(`WORD_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

    // r0 is never written since wb.valid excludes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // write before read
    assign rs_val = (wb.valid && wb.idx == rs) ? wb.data : regs[rs];
    assign rt_val = (wb.valid && wb.idx == rt) ? wb.data : regs[rt];

    always_comb begin
        alu_op  = alu_add;
        mem_ctl = '0;
        writes  = 1'b0;
        b_imm   = 1'b0;
        uses_rt = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        dest    = rd;
        src_rt  = rt;
        case (opcode)
            op_rtype: begin
                uses_rt = 1'b1;
                writes  = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: writes = 1'b0;
                endcase
            end
            // rt is a destination here, so nothing forwards into b
            op_addi: begin
                writes = 1'b1;
                dest   = rt;
                src_rt = '0;
                b_imm  = 1'b1;
            end
            op_lw: begin
                writes              = 1'b1;
                dest                = rt;
                src_rt              = '0;
                b_imm               = 1'b1;
                mem_ctl[mem_rd_bit] = 1'b1;
            end
            op_sw: begin
                uses_rt             = 1'b1;
                b_imm               = 1'b1;
                mem_ctl[mem_wr_bit] = 1'b1;
            end
            op_beq: begin
                uses_rt = 1'b1;
                is_beq  = 1'b1;
            end
            op_bne: begin
                uses_rt = 1'b1;
                is_bne  = 1'b1;
            end
            default: ;
        endcase
    end

    assign operands_eq   = (rs_val == rt_val);
    assign branch_target = id_pc + word_t'(4) + (imm_ext << 2);

    assign hz.id_rs        = rs;
    assign hz.id_rt        = rt;
    assign hz.id_uses_rt   = uses_rt;
    assign hz.id_is_branch = id_valid && (is_beq || is_bne);
    assign hz.branch_taken = id_valid && ((is_beq && operands_eq) || (is_bne && !operands_eq));

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (hz.pipe_clear || hz.ex_bubble) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_a       <= rs_val;
        ex_b       <= b_imm ? imm_ext : rt_val;
        ex_store   <= rt_val;
        ex_rs      <= rs;
        ex_rt      <= src_rt;
        ex_dest    <= dest;
        ex_alu_op  <= alu_op;
        ex_mem_ctl <= mem_ctl;
        ex_writes  <= writes && (dest != '0);
    end

endmodule

// File: hazard_control.sv
`timescale 1ns/1ps

module hazard_control
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    hazard_if.ctl hz
);

    logic run_q, load_use, branch_dep, stall;

    function automatic logic hits(reg_idx_t dest, reg_idx_t src);
        return (dest != '0) && (dest == src);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= run;
        end
    end

    // consumer in ID, load still in EX
    assign load_use = hz.ex_is_load &&
                      (hits(hz.ex_dest, hz.id_rs) || (hz.id_uses_rt && hits(hz.ex_dest, hz.id_rt)));

    // branch compares in ID, so its operands must already be in the regfile or WB
    assign branch_dep = hz.id_is_branch &&
                        ((hz.ex_writes && (hits(hz.ex_dest, hz.id_rs) ||
                                           hits(hz.ex_dest, hz.id_rt))) ||
                         (hz.mem_writes && (hits(hz.mem_dest, hz.id_rs) ||
                                            hits(hz.mem_dest, hz.id_rt))));

    assign stall = load_use || branch_dep;

    // one extra cleared cycle after run rises lets the last load settle
    assign hz.pipe_clear = !run || !run_q;
    assign hz.if_hold    = stall;
    assign hz.ex_bubble  = stall;
    assign hz.id_flush   = hz.branch_taken && !stall;

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     ex_a,
    input  word_t     ex_b,
    input  word_t     ex_store,
    input  reg_idx_t  ex_rs,
    input  reg_idx_t  ex_rt,
    input  reg_idx_t  ex_dest,
    input  alu_op_t   ex_alu_op,
    input  mem_ctl_t  ex_mem_ctl,
    input  logic      ex_writes,
    input  logic      ex_valid,
    hazard_if.execute hz,
    wb_if.sink        wb,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output reg_idx_t  mem_dest,
    output mem_ctl_t  mem_ctl,
    output logic      mem_writes,
    output logic      mem_valid
);

    fwd_sel_t sel_a, sel_b, sel_rt;
    word_t    op_a, op_b, store_val, alu_y;
    logic     mem_fwd_ok;

    // a load in MEM has no data yet and relies on the load-use stall
    assign mem_fwd_ok = wb.mem_valid_write && !wb.is_load_mem;

    function automatic fwd_sel_t pick(reg_idx_t src);
        if (src == '0) return fwd_none;
        if (mem_fwd_ok && wb.mem_idx == src) return fwd_from_mem;
        if (wb.valid && wb.idx == src) return fwd_from_wb;
        return fwd_none;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
        case (sel)
            fwd_from_mem: return wb.mem_data;
            fwd_from_wb:  return wb.data;
            default:      return reg_val;
        endcase
    endfunction

    always_comb begin
        sel_a  = pick(ex_rs);
        sel_rt = pick(ex_rt);
        // sw carries its offset in b and rt feeds store data only
        sel_b  = ex_mem_ctl[mem_wr_bit] ? fwd_none : sel_rt;

        op_a      = fwd_mux(sel_a, ex_a);
        op_b      = fwd_mux(sel_b, ex_b);
        store_val = fwd_mux(sel_rt, ex_store);
    end

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_y = op_a - op_b;
            alu_and: alu_y = op_a & op_b;
            alu_or:  alu_y = op_a | op_b;
            alu_slt: alu_y = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: alu_y = op_a + op_b;
        endcase
    end

    assign hz.ex_dest    = ex_dest;
    assign hz.ex_writes  = ex_valid && ex_writes;
    assign hz.ex_is_load = ex_valid && ex_mem_ctl[mem_rd_bit];

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n || hz.pipe_clear) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr   <= alu_y;
        mem_wdata  <= store_val;
        mem_dest   <= ex_dest;
        mem_ctl    <= ex_mem_ctl;
        mem_writes <= ex_writes;
    end

endmodule

// File: mem_stage.sv
`include "cpu_params.svh"
`timescale 1ns/1ps

module mem_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    mem_addr,
    input  word_t    mem_wdata,
    input  reg_idx_t mem_dest,
    input  mem_ctl_t mem_ctl,
    input  logic     mem_writes,
    input  logic     mem_valid,
    hazard_if.mem    hz,
    wb_if.src        wb,
    output logic     store_valid,
    output word_t    store_addr,
    output word_t    store_data
);

    logic [`DMEM_ADDR_WIDTH-1:0] dmem_idx;
    word_t    rdata, wb_alu_q, wb_rdata_q;
    reg_idx_t wb_idx_q;
    logic     wb_valid_q, wb_load_q;

    word_t dmem [`DMEM_DEPTH] = '{default: '0};

    // byte address, word index wraps at the depth
    assign dmem_idx = mem_addr[`DMEM_ADDR_WIDTH+1:2];
    assign rdata    = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (store_valid) begin
            dmem[dmem_idx] <= mem_wdata;
        end
    end

    assign store_valid = mem_valid && mem_ctl[mem_wr_bit];
    assign store_addr  = mem_addr;
    assign store_data  = mem_wdata;

    assign hz.mem_dest   = mem_dest;
    assign hz.mem_writes = mem_valid && mem_writes;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n || hz.pipe_clear) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= mem_valid && mem_writes;
        end
    end

    always_ff @(posedge clk) begin
        wb_idx_q   <= mem_dest;
        wb_alu_q   <= mem_addr;
        wb_rdata_q <= rdata;
        wb_load_q  <= mem_ctl[mem_rd_bit];
    end

    assign wb.valid = wb_valid_q;
    assign wb.idx   = wb_idx_q;
    assign wb.data  = wb_load_q ? wb_rdata_q : wb_alu_q;

    assign wb.is_load_mem     = mem_valid && mem_ctl[mem_rd_bit];
    assign wb.mem_valid_write = mem_valid && mem_writes;
    assign wb.mem_idx         = mem_dest;
    assign wb.mem_data        = mem_addr;

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  instr_t     load_data,
    output logic       wb_valid,
    output reg_idx_t   wb_idx,
    output word_t      wb_data,
    output logic       store_valid,
    output word_t      store_addr,
    output word_t      store_data
);

    hazard_if hz ();
    wb_if     wb ();

    // IF/ID
    word_t    id_pc, branch_target;
    instr_t   id_instr;
    logic     id_valid;

    // ID/EX
    word_t    ex_a, ex_b, ex_store;
    reg_idx_t ex_rs, ex_rt, ex_dest;
    alu_op_t  ex_alu_op;
    mem_ctl_t ex_mem_ctl;
    logic     ex_writes, ex_valid;

    // EX/MEM
    word_t    mem_addr, mem_wdata;
    reg_idx_t mem_dest;
    mem_ctl_t mem_ctl;
    logic     mem_writes, mem_valid;

    hazard_control hazard_control_i (.*);
    fetch_stage    fetch_stage_i (.*);
    decode_stage   decode_stage_i (.*);
    execute_stage  execute_stage_i (.*);
    mem_stage      mem_stage_i (.*);

    assign wb_valid = wb.valid;
    assign wb_idx   = wb.idx;
    assign wb_data  = wb.data;

endmodule

// File: cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties
    import isa_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     run,
    input logic     wb_valid,
    input reg_idx_t wb_idx,
    input logic     store_valid
);

    // strobes drop one cycle after reset or hold
    property quiet_after_reset;
        @(posedge clk) !rst_n |=> (!wb_valid && !store_valid);
    endproperty

    property quiet_while_held;
        @(posedge clk) !run |=> (!wb_valid && !store_valid);
    endproperty

    property no_r0_write;
        @(posedge clk) disable iff (!rst_n) wb_valid |-> (wb_idx != '0);
    endproperty

    quiet_after_reset_a: assert property (quiet_after_reset)
        else $error("write or store strobe high in the cycle after reset");

    quiet_while_held_a: assert property (quiet_while_held)
        else $error("write or store strobe high while the core is held");

    no_r0_write_a: assert property (no_r0_write)
        else $error("register write to r0 shown on wb_valid");

endmodule

// File: cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb
    import isa_pkg::*;
();

    localparam int prog_len       = 48;
    localparam int num_progs      = 4;
    localparam int reset_cycles   = 5;
    localparam int timeout_cycles = 8 * num_progs * prog_len + reset_cycles;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       load_en;
    imem_addr_t load_addr;
    instr_t     load_data;
    logic       wb_valid;
    reg_idx_t   wb_idx;
    word_t      wb_data;
    logic       store_valid;
    word_t      store_addr;
    word_t      store_data;

    logic [31:0] lfsr_state;
    instr_t      prog [prog_len];
    word_t       ref_regs [`REG_COUNT];
    word_t       ref_mem [`DMEM_DEPTH];
    reg_idx_t    exp_wb_idx [$];
    word_t       exp_wb_data [$];
    word_t       exp_st_addr [$];
    word_t       exp_st_data [$];
    int          cycles = 0;

    cpu_top dut_i (.*);

    bind cpu_top cpu_properties props_i (.clk(clk), .rst_n(rst_n), .run(run),
        .wb_valid(wb_valid), .wb_idx(wb_idx), .store_valid(store_valid));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        fail_now($sformatf("[FAIL] t=%0t %s got 0x%08h expected 0x%08h",
                           $time, name, got, exp));
    endtask

    // galois taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, funct_e fn);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instr_t gen_instr();
        logic [31:0] kind, pick;
        reg_idx_t    rs, rt, rd;
        funct_e      fn;
        kind = take_bits(4);
        rs   = reg_idx_t'(take_bits(3));
        rt   = reg_idx_t'(take_bits(3));
        rd   = reg_idx_t'(take_bits(3));
        if (kind < 6) begin
            pick = take_bits(3) % 5;
            case (pick)
                0:       fn = fn_add;
                1:       fn = fn_sub;
                2:       fn = fn_and;
                3:       fn = fn_or;
                default: fn = fn_slt;
            endcase
            return enc_r(rs, rt, rd, fn);
        end
        if (kind < 9 || kind == 15) begin
            pick = take_bits(8);
            return enc_i(op_addi, rs, rt, {{8{pick[7]}}, pick[7:0]});
        end
        // base r0 with a word offset below 64
        if (kind < 13) begin
            pick = take_bits(4) << 2;
            if (kind < 11) begin
                return enc_i(op_lw, '0, rt, pick[15:0]);
            end
            return enc_i(op_sw, '0, rt, pick[15:0]);
        end
        // forward by 1 to 3 and sometimes against itself
        if (take_bits(1) == 1) begin
            rt = rs;
        end
        pick = 1 + take_bits(2) % 3;
        if (kind == 13) begin
            return enc_i(op_beq, rs, rt, pick[15:0]);
        end
        return enc_i(op_bne, rs, rt, pick[15:0]);
    endfunction

    function automatic void record_write(input reg_idx_t idx, input word_t val);
        // r0 stays zero
        if (idx != '0) begin
            ref_regs[idx] = val;
            exp_wb_idx.push_back(idx);
            exp_wb_data.push_back(val);
        end
    endfunction

    // executes one instruction and returns the next index
    function automatic int ref_step(input instr_t ins, input int pc);
        reg_idx_t rs, rt, rd;
        word_t    a, b, imm, addr;
        int       next;
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        a    = ref_regs[rs];
        b    = ref_regs[rt];
        imm  = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        next = pc + 1;
        case (opcode_e'(ins[31:26]))
            op_rtype: begin
                case (funct_e'(ins[5:0]))
                    fn_add:  record_write(rd, a + b);
                    fn_sub:  record_write(rd, a - b);
                    fn_and:  record_write(rd, a & b);
                    fn_or:   record_write(rd, a | b);
                    fn_slt:  record_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;
                endcase
            end
            op_addi: record_write(rt, addr);
            op_lw:   record_write(rt, ref_mem[addr[`DMEM_ADDR_WIDTH+1:2]]);
            op_sw: begin
                ref_mem[addr[`DMEM_ADDR_WIDTH+1:2]] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            op_beq:  next = (a == b) ? pc + 1 + int'($signed(imm)) : next;
            op_bne:  next = (a != b) ? pc + 1 + int'($signed(imm)) : next;
            default: ;
        endcase
        return next;
    endfunction

    task automatic run_reference();
        int pc;
        pc = 0;
        while (pc < prog_len) begin
            pc = ref_step(prog[pc], pc);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = imem_addr_t'(i);
            load_data = prog[i];
        end
        @(posedge clk);
        #1 load_en = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        lfsr_state = 32'hf5b6_4a6e;
        for (int i = 0; i < `REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int p = 0; p < num_progs; p++) begin
            for (int i = 0; i < prog_len; i++) begin
                prog[i] = gen_instr();
            end
            run_reference();
            load_program();
            @(posedge clk);
            #1 run = 1'b1;
            // compare process empties the queues as the core retires
            // stray loads while running must leave the program untouched
            while (exp_wb_idx.size() != 0 || exp_st_addr.size() != 0) begin
                @(posedge clk);
                #1;
                load_en   = 1'b1;
                load_addr = imem_addr_t'(take_bits(6));
                load_data = enc_i(op_addi, 5'd0, 5'd7, 16'h5a5a);
            end
            run     = 1'b0;
            load_en = 1'b0;
            repeat (4) @(posedge clk);
        end
        $display("Finished with no errors");
        $finish;
    end

    // sampled mid-cycle while inputs move 1 ns after the rising edge
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            assert (wb_idx != '0)
                else fail_now("a write to r0 appeared on wb_valid");
            assert (exp_wb_idx.size() != 0)
                else fail_now($sformatf("unexpected register write to r%0d", wb_idx));
            assert (wb_idx == exp_wb_idx[0])
                else report_mismatch("wb_idx", word_t'(wb_idx), word_t'(exp_wb_idx[0]));
            assert (wb_data == exp_wb_data[0])
                else report_mismatch("wb_data", wb_data, exp_wb_data[0]);
            void'(exp_wb_idx.pop_front());
            void'(exp_wb_data.pop_front());
        end
        if (rst_n && store_valid) begin
            assert (exp_st_addr.size() != 0)
                else fail_now($sformatf("unexpected store to address 0x%08h", store_addr));
            assert (store_addr == exp_st_addr[0])
                else report_mismatch("store_addr", store_addr, exp_st_addr[0]);
            assert (store_data == exp_st_data[0])
                else report_mismatch("store_data", store_data, exp_st_data[0]);
            void'(exp_st_addr.pop_front());
            void'(exp_st_data.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles < timeout_cycles)
            else fail_now($sformatf("timeout, programs not done after %0d cycles", cycles));
    end

endmodule

// File: files.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pipe_if.sv
fetch_stage.sv
decode_stage.sv
hazard_control.sv
execute_stage.sv
mem_stage.sv
cpu_top.sv
cpu_properties.sv
cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) cpu_params.svh
PASS_MSG  = Finished with no errors

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
